// File: include/cpu_dispatch_settings.svh
`ifndef CPU_DISPATCH_SETTINGS_SVH
`define CPU_DISPATCH_SETTINGS_SVH

// number of cpus sharing the dispatcher
// 2, 4 and 8 are all fine
`define CPU_COUNT 4

// memory word address width
`define ADDR_W 8

// data word width
`define DATA_W 32

// words in the shared memory
// keep at 2**ADDR_W so every address hits a word
`define MEM_DEPTH 256

`endif

// File: hdl/cpu_dispatch_pkg.sv
`default_nettype none

`include "cpu_dispatch_settings.svh"

package cpu_dispatch_pkg;

  // index width is at least one bit even for a single cpu
  localparam int CPU_IDX_W = (`CPU_COUNT > 1) ? $clog2(`CPU_COUNT) : 1;

  typedef logic [CPU_IDX_W-1:0] cpu_index_t;
  typedef logic [`ADDR_W-1:0]   addr_t;
  typedef logic [`DATA_W-1:0]   data_t;

  // highest cpu number where round robin wraps
  localparam cpu_index_t CPU_LAST = cpu_index_t'(`CPU_COUNT - 1);

  // slice currently handed out by the scheduler
  typedef struct packed {
    logic       active;
    cpu_index_t cpu_index;
    addr_t      resume_addr;
  } slot_grant_t;

  // one memory access tagged with the cpu that asked for it
  typedef struct packed {
    logic       valid;
    logic       write;
    cpu_index_t cpu_index;
    addr_t      addr;
    data_t      wdata;
  } mem_req_t;

  // completion of an access
  typedef struct packed {
    logic       read_done;
    logic       write_done;
    cpu_index_t cpu_index;
    addr_t      addr;
    data_t      rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    ctl_reset_wait,
    ctl_cpu_loop,
    ctl_cpu_cmd
  } ctl_state_e;

endpackage

`default_nettype wire

// File: hdl/cpu_slot_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_dispatch_settings.svh"

module cpu_slot_scheduler import cpu_dispatch_pkg::*; (
  input  wire         clk,
  input  wire         ext_rst_e,
  input  wire         cpu_e,
  input  addr_t       next_addr,
  output logic        cpu_rst,
  output logic        cpu_q,
  output slot_grant_t grant
);

  ctl_state_e state;
  cpu_index_t cpu_num;
  logic       cpu_q_r;
  logic       grant_active;
  cpu_index_t grant_index;
  addr_t      grant_resume;

  // resume address per cpu
  addr_t      resume_tbl [`CPU_COUNT];
  logic       tbl_we;
  addr_t      tbl_wd;

  function automatic cpu_index_t next_index(input cpu_index_t idx);
    if (idx == CPU_LAST) begin
      return '0;
    end
    return idx + cpu_index_t'(1);
  endfunction

  // cpus stay in reset until every table entry is cleared
  assign cpu_rst = (state == ctl_reset_wait);

  // clearing walks the table
  // end of slice stores the resume point
  assign tbl_we = (state == ctl_reset_wait) || ((state == ctl_cpu_cmd) && cpu_e);
  assign tbl_wd = (state == ctl_reset_wait) ? '0 : next_addr;

  always_ff @(posedge clk) begin
    if (tbl_we) begin
      resume_tbl[cpu_num] <= tbl_wd;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state        <= ctl_reset_wait;
      cpu_num      <= '0;
      cpu_q_r      <= 1'b0;
      grant_active <= 1'b0;
    end else begin
      cpu_q_r <= 1'b0;
      case (state)
        ctl_reset_wait: begin
          // cpu_num doubles as the clear pointer and wraps back to 0
          cpu_num <= next_index(cpu_num);
          if (cpu_num == CPU_LAST) begin
            state <= ctl_cpu_loop;
          end
        end
        ctl_cpu_loop: begin
          cpu_q_r      <= 1'b1;
          grant_active <= 1'b1;
          state        <= ctl_cpu_cmd;
        end
        ctl_cpu_cmd: begin
          if (cpu_e) begin
            grant_active <= 1'b0;
            cpu_num      <= next_index(cpu_num);
            state        <= ctl_cpu_loop;
          end
        end
        default: begin
          state <= ctl_reset_wait;
        end
      endcase
    end
  end

  // index and resume point are latched together with the start pulse
  always_ff @(posedge clk) begin
    if (state == ctl_cpu_loop) begin
      grant_index  <= cpu_num;
      grant_resume <= resume_tbl[cpu_num];
    end
  end

  assign cpu_q             = cpu_q_r;
  assign grant.active      = grant_active;
  assign grant.cpu_index   = grant_index;
  assign grant.resume_addr = grant_resume;

endmodule

`default_nettype wire

// File: hdl/bus_request_capture.sv
`timescale 1ns/1ps
`default_nettype none

module bus_request_capture import cpu_dispatch_pkg::*; (
  input  wire         clk,
  input  wire         ext_rst_e,
  input  slot_grant_t grant,
  input  wire         read_q,
  input  wire         write_q,
  input  addr_t       addr,
  input  data_t       wdata,
  output mem_req_t    mem_req
);

  logic       req_valid;
  logic       req_write;
  cpu_index_t req_index;
  addr_t      req_addr;
  data_t      req_wdata;
  logic       strobe;

  // any strobe counts but only inside an active slice
  assign strobe = grant.active && (read_q || write_q);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= strobe;
    end
  end

  // payload follows the bus every cycle
  // valid decides whether the memory port looks at it
  always_ff @(posedge clk) begin
    // read wins when both strobes are up
    req_write <= write_q && !read_q;
    req_index <= grant.cpu_index;
    req_addr  <= addr;
    req_wdata <= wdata;
  end

  assign mem_req.valid     = req_valid;
  assign mem_req.write     = req_write;
  assign mem_req.cpu_index = req_index;
  assign mem_req.addr      = req_addr;
  assign mem_req.wdata     = req_wdata;

endmodule

`default_nettype wire

// File: hdl/shared_memory_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_dispatch_settings.svh"

module shared_memory_port import cpu_dispatch_pkg::*; (
  input  wire      clk,
  input  wire      ext_rst_e,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  // shared word array with contents undefined until written
  data_t      mem [`MEM_DEPTH];

  logic       rd_done_q;
  logic       wr_done_q;
  cpu_index_t rsp_index_q;
  addr_t      rsp_addr_q;
  data_t      rdata_q;
  logic       do_read;
  logic       do_write;

  assign do_read  = mem_req.valid && !mem_req.write;
  assign do_write = mem_req.valid && mem_req.write;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[mem_req.addr] <= mem_req.wdata;
    end
  end

  // read samples the word before any write at the same edge
  always_ff @(posedge clk) begin
    if (do_read) begin
      rdata_q <= mem[mem_req.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      rd_done_q <= 1'b0;
      wr_done_q <= 1'b0;
    end else begin
      rd_done_q <= do_read;
      wr_done_q <= do_write;
    end
  end

  // tag and address travel with the done strobe
  always_ff @(posedge clk) begin
    if (mem_req.valid) begin
      rsp_index_q <= mem_req.cpu_index;
      rsp_addr_q  <= mem_req.addr;
    end
  end

  assign mem_rsp.read_done  = rd_done_q;
  assign mem_rsp.write_done = wr_done_q;
  assign mem_rsp.cpu_index  = rsp_index_q;
  assign mem_rsp.addr       = rsp_addr_q;
  assign mem_rsp.rdata      = rdata_q;

endmodule

`default_nettype wire

// File: hdl/cpu_dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_dispatch_top import cpu_dispatch_pkg::*; (
  input  wire        clk,
  input  wire        ext_rst_e,
  input  wire        read_q,
  input  wire        write_q,
  input  addr_t      addr,
  input  data_t      wdata,
  input  wire        cpu_e,
  input  addr_t      next_addr,
  output logic       cpu_rst,
  output logic       cpu_q,
  output cpu_index_t cpu_index,
  output addr_t      resume_addr,
  output logic       read_done,
  output logic       write_done,
  output cpu_index_t rsp_cpu_index,
  output addr_t      rsp_addr,
  output data_t      rdata
);

  slot_grant_t grant;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;

  // slice control
  cpu_slot_scheduler cpu_slot_scheduler_i (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .cpu_e     (cpu_e),
    .next_addr (next_addr),
    .cpu_rst   (cpu_rst),
    .cpu_q     (cpu_q),
    .grant     (grant)
  );

  bus_request_capture bus_request_capture_i (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .grant     (grant),
    .read_q    (read_q),
    .write_q   (write_q),
    .addr      (addr),
    .wdata     (wdata),
    .mem_req   (mem_req)
  );

  shared_memory_port shared_memory_port_i (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

  // grant and response fields out to the cpu side
  assign cpu_index     = grant.cpu_index;
  assign resume_addr   = grant.resume_addr;
  assign read_done     = mem_rsp.read_done;
  assign write_done    = mem_rsp.write_done;
  assign rsp_cpu_index = mem_rsp.cpu_index;
  assign rsp_addr      = mem_rsp.addr;
  assign rdata         = mem_rsp.rdata;

endmodule

`default_nettype wire

// File: verification/cpu_dispatch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_dispatch_tb import cpu_dispatch_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_LINES    = 40;
  // words per vector line with 4 stimulus and 6 expected
  localparam int FIELDS       = 10;

  logic       clk;
  logic       ext_rst_e;
  logic       read_q;
  logic       write_q;
  addr_t      addr;
  data_t      wdata;
  logic       cpu_e;
  addr_t      next_addr;
  logic       cpu_rst;
  logic       cpu_q;
  cpu_index_t cpu_index;
  addr_t      resume_addr;
  logic       read_done;
  logic       write_done;
  cpu_index_t rsp_cpu_index;
  addr_t      rsp_addr;
  data_t      rdata;

  logic [31:0] vectors [0:NUM_LINES*FIELDS-1];
  int          cur_line;
  ctl_state_e  sched_state;

  cpu_dispatch_top cpu_dispatch_top_i (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .read_q        (read_q),
    .write_q       (write_q),
    .addr          (addr),
    .wdata         (wdata),
    .cpu_e         (cpu_e),
    .next_addr     (next_addr),
    .cpu_rst       (cpu_rst),
    .cpu_q         (cpu_q),
    .cpu_index     (cpu_index),
    .resume_addr   (resume_addr),
    .read_done     (read_done),
    .write_done    (write_done),
    .rsp_cpu_index (rsp_cpu_index),
    .rsp_addr      (rsp_addr),
    .rdata         (rdata)
  );

  // scheduler state for error context
  assign sched_state = cpu_dispatch_top_i.cpu_slot_scheduler_i.state;

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch at %0t ns, line %0d: %s expected %h, got %h",
               $time, cur_line, name, expected, actual);
      $display("scheduler in %s", sched_state.name());
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // first word holds read in bit 2, write in bit 1 and end of slice in bit 0
  task automatic apply_line(input int line);
    int          base;
    logic [31:0] flags;
    base  = line * FIELDS;
    flags = vectors[base];
    ext_rst_e <= (line < RESET_CYCLES);
    read_q    <= flags[2];
    write_q   <= flags[1];
    cpu_e     <= flags[0];
    addr      <= addr_t'(vectors[base + 1]);
    wdata     <= data_t'(vectors[base + 2]);
    next_addr <= addr_t'(vectors[base + 3]);
  endtask

  // expected strobes sit in bit 3 cpu_rst, bit 2 cpu_q, bit 1 read_done and bit 0 write_done
  task automatic check_line(input int line);
    int          base;
    logic [31:0] flags;
    base  = line * FIELDS;
    flags = vectors[base + 4];
    compare_value("cpu_rst", 32'(flags[3]), 32'(cpu_rst));
    compare_value("cpu_q", 32'(flags[2]), 32'(cpu_q));
    compare_value("read_done", 32'(flags[1]), 32'(read_done));
    compare_value("write_done", 32'(flags[0]), 32'(write_done));
    // index and resume point only count with the start pulse
    if (flags[2]) begin
      compare_value("cpu_index", vectors[base + 5], 32'(cpu_index));
      compare_value("resume_addr", vectors[base + 6], 32'(resume_addr));
    end
    // response tag valid with either done strobe
    if (flags[1] || flags[0]) begin
      compare_value("rsp_cpu_index", vectors[base + 7], 32'(rsp_cpu_index));
      compare_value("rsp_addr", vectors[base + 8], 32'(rsp_addr));
    end
    if (flags[1]) begin
      compare_value("rdata", vectors[base + 9], 32'(rdata));
    end
  endtask

  initial begin
    ext_rst_e = 1'b1;
    read_q    = 1'b0;
    write_q   = 1'b0;
    addr      = '0;
    wdata     = '0;
    cpu_e     = 1'b0;
    next_addr = '0;
    cur_line  = 0;
    $readmemh("verification/cpu_dispatch_vectors.hex", vectors);
    // inputs change after the edge
    // outputs are read mid cycle
    for (int i = 0; i < NUM_LINES; i++) begin
      @(posedge clk);
      apply_line(i);
      @(negedge clk);
      cur_line = i;
      check_line(i);
    end
    $display("TEST OK");
    $finish;
  end

  // all vector lines plus some slack
  initial begin
    #(CLK_PERIOD * (NUM_LINES + 20));
    $display("timeout: vectors not done after %0d clock cycles", NUM_LINES + 20);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: cpu_dispatch_top.f
+incdir+include
hdl/cpu_dispatch_pkg.sv
hdl/cpu_slot_scheduler.sv
hdl/bus_request_capture.sv
hdl/shared_memory_port.sv
hdl/cpu_dispatch_top.sv
verification/cpu_dispatch_tb.sv

// File: Makefile
SIM  := obj_dir/Vcpu_dispatch_tb
SRCS := $(shell grep -v '^+' cpu_dispatch_top.f) include/cpu_dispatch_settings.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, the header or the file list changes
$(SIM): $(SRCS) cpu_dispatch_top.f
	verilator --binary --timing --assert -f cpu_dispatch_top.f --top-module cpu_dispatch_tb

# the simulator exit status is ignored, the log decides
run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx 'TEST OK' sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/cpu_dispatch_vectors.hex
// in:  strobes(read_q write_q cpu_e) addr wdata next_addr
// exp: strobes(cpu_rst cpu_q read_done write_done) cpu_index resume_addr rsp_cpu_index rsp_addr rdata
0 00 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
2 10 DEADBEEF 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
4 20 00000000 00 8 0 00 0 00 00000000
0 00 00000000 00 8 0 00 0 00 00000000
2 10 11111111 00 0 0 00 0 00 00000000
2 20 A5A50001 00 4 0 00 0 00 00000000
2 10 12345678 00 0 0 00 0 00 00000000
4 20 00000000 00 1 0 00 0 20 00000000
4 10 00000000 00 1 0 00 0 10 00000000
3 21 0000C0DE 40 2 0 00 0 20 A5A50001
2 10 BADBAD00 00 2 0 00 0 10 12345678
4 21 00000000 00 5 1 00 0 21 00000000
4 10 00000000 00 0 0 00 0 00 00000000
1 00 00000000 55 2 0 00 1 21 0000C0DE
4 20 00000000 00 2 0 00 1 10 12345678
2 30 CAFE0030 00 4 2 00 0 00 00000000
2 31 CAFE0031 00 0 0 00 0 00 00000000
2 32 CAFE0032 00 1 0 00 2 30 00000000
4 30 00000000 00 1 0 00 2 31 00000000
4 31 00000000 00 1 0 00 2 32 00000000
4 32 00000000 00 2 0 00 2 30 CAFE0030
1 00 00000000 66 2 0 00 2 31 CAFE0031
0 00 00000000 00 2 0 00 2 32 CAFE0032
6 30 FFFFFFFF 00 4 3 00 0 00 00000000
4 30 00000000 00 0 0 00 0 00 00000000
1 00 00000000 77 2 0 00 3 30 CAFE0030
0 00 00000000 00 2 0 00 3 30 CAFE0030
1 00 00000000 41 4 0 40 0 00 00000000
0 00 00000000 00 0 0 00 0 00 00000000
0 00 00000000 00 4 1 55 0 00 00000000
